// File: verilog.f
rtl/pipePkg.sv
rtl/isaPkg.sv
rtl/stageIf.sv
rtl/registerFile.sv
rtl/fetchUnit.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/coreTop.sv
verification/tbClock.sv
verification/coreChecker.sv
verification/coreTb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary -Wno-fatal -j 0
TOP ?= coreTb
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
PASS_TEXT = Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: verification/coreTb.sv
// Core testbench; programs hold at most 32 words, start at 1000 hex and end by falling off their last word
`timescale 1ns/100ps

module coreTb import pipePkg::*, isaPkg::*; ();

  localparam word resetPc = 32'h0000_1000;
  // Program memory of 32 words indexed by address bits 6..2
  localparam int progDepth = 32;
  localparam int maxSteps = 64;
  localparam int maxWait = 3;
  localparam int resetCycles = 8;
  localparam int clkPeriod = 4;
  localparam int numPrograms = 4;
  // Each program runs once with no waits and once with random waits
  localparam int numRuns = 2 * numPrograms;
  // Up to three fetches per step when a taken branch drops two words
  // Each fetch waits up to maxWait cycles
  localparam int runCycles = resetCycles + 16 + maxSteps * 3 * (maxWait + 1);
  localparam int watchdogNs = 2 * numRuns * runCycles * clkPeriod;

  logic  clk;
  logic  rst;
  logic  resetRequest;
  word   instAddr;
  word   instData;
  logic  instValid;
  logic  retireValid;
  regIdx retireReg;
  word   retireData;

  word   progMem [progDepth];
  int    progLen;
  string progName;
  regIdx expRegs [maxSteps];
  word   expData [maxSteps];
  int    expCount;
  logic  runEnd;
  int    retiredCount;
  int    checkErrors;
  logic  runClosed;

  int    seed;
  int    waitLeft;
  logic  randomWaits;
  int    testsRun;
  int    testsFailed;
  int    totalErrors;

  tbClock #(.resetCycles(resetCycles), .halfPeriod(clkPeriod / 2)) u_tbClock
  (
    .resetRequest (resetRequest),
    .clk          (clk),
    .rst          (rst)
  );

  coreTop #(.resetPc(resetPc)) u_coreTop
  (
    .clk         (clk),
    .rst         (rst),
    .instAddr    (instAddr),
    .instData    (instData),
    .instValid   (instValid),
    .retireValid (retireValid),
    .retireReg   (retireReg),
    .retireData  (retireData)
  );

  coreChecker #(.maxRetires(maxSteps)) u_coreChecker
  (
    .clk          (clk),
    .rst          (rst),
    .retireValid  (retireValid),
    .retireReg    (retireReg),
    .retireData   (retireData),
    .expCount     (expCount),
    .expRegs      (expRegs),
    .expData      (expData),
    .runEnd       (runEnd),
    .retiredCount (retiredCount),
    .errorCount   (checkErrors),
    .runClosed    (runClosed)
  );

  // Register-register form
  function automatic word aluWord(input opcode op, input regIdx d, input regIdx a, input regIdx b);
    word w;
    w = '0;
    w[opcodeLsb +: opcodeBits] = op;
    w[dstLsb +: regIdxBits] = d;
    w[src1Lsb +: regIdxBits] = a;
    w[src2Lsb +: regIdxBits] = b;
    return w;
  endfunction

  // Immediate form whose low 15 bits also cover the source 2 field
  function automatic word immWord(input opcode op, input regIdx d, input regIdx a, input int imm);
    word w;
    w = '0;
    w[opcodeLsb +: opcodeBits] = op;
    w[dstLsb +: regIdxBits] = d;
    w[src1Lsb +: regIdxBits] = a;
    w[immBits-1:0] = imm[immBits-1:0];
    return w;
  endfunction

  task automatic emit(input word w);
    progMem[progLen[4:0]] = w;
    progLen++;
  endtask

  task automatic loadProgram(input int which);
    progLen = 0;
    // Unused words still decode as NOP but carry their own index
    for (int i = 0; i < progDepth; i++)
      progMem[i] = nopInstruction ^ word'(i);
    case (which)
      // Plain arithmetic, negative and extreme immediates, NOP and an unknown opcode
      0:
      begin
        progName = "arith";
        emit(immWord(opMovi, 5'd1, 5'd0, 5));
        emit(immWord(opMovi, 5'd2, 5'd0, -3));
        emit(immWord(opMovi, 5'd3, 5'd0, 1000));
        emit(immWord(opMovi, 5'd7, 5'd0, -16384));
        emit(nopInstruction);
        emit(32'h5400_0000);
        emit(aluWord(opAdd, 5'd4, 5'd1, 5'd2));
        emit(aluWord(opSub, 5'd5, 5'd3, 5'd1));
        emit(aluWord(opSub, 5'd6, 5'd2, 5'd3));
        emit(aluWord(opAdd, 5'd8, 5'd7, 5'd7));
        emit(immWord(opMovi, 5'd9, 5'd0, 16383));
      end
      // Every instruction reads the one just before it
      1:
      begin
        progName = "forward";
        emit(immWord(opMovi, 5'd1, 5'd0, 7));
        emit(aluWord(opAdd, 5'd2, 5'd1, 5'd1));
        emit(aluWord(opAdd, 5'd3, 5'd2, 5'd1));
        emit(aluWord(opSub, 5'd4, 5'd3, 5'd2));
        emit(aluWord(opAdd, 5'd4, 5'd4, 5'd4));
        emit(aluWord(opSub, 5'd1, 5'd4, 5'd3));
        emit(aluWord(opAdd, 5'd5, 5'd1, 5'd1));
        // Only source 2 needs the forwarded value here
        emit(aluWord(opSub, 5'd5, 5'd1, 5'd5));
      end
      // BEQ against r0 which is never written
      // Small offsets keep src2 at r0
      2:
      begin
        progName = "branch";
        emit(immWord(opMovi, 5'd1, 5'd0, 1));
        emit(immWord(opMovi, 5'd3, 5'd0, 11));
        emit(immWord(opBeq, 5'd0, 5'd1, 3));
        emit(immWord(opMovi, 5'd2, 5'd0, 0));
        emit(immWord(opBeq, 5'd0, 5'd2, 3));
        emit(immWord(opMovi, 5'd4, 5'd0, 99));
        emit(immWord(opMovi, 5'd5, 5'd0, 98));
        emit(immWord(opMovi, 5'd9, 5'd0, 4096));
        emit(immWord(opJump, 5'd0, 5'd9, 12));
        emit(immWord(opMovi, 5'd6, 5'd0, 97));
        emit(aluWord(opAdd, 5'd6, 5'd9, 5'd9));
        emit(immWord(opMovi, 5'd7, 5'd0, 96));
        emit(aluWord(opAdd, 5'd8, 5'd3, 5'd1));
      end
      // Countdown loop, backward JUMP and forward BEQ exit
      default:
      begin
        progName = "loop";
        emit(immWord(opMovi, 5'd1, 5'd0, 3));
        emit(immWord(opMovi, 5'd2, 5'd0, 1));
        emit(immWord(opMovi, 5'd9, 5'd0, 4096));
        emit(aluWord(opAdd, 5'd3, 5'd3, 5'd1));
        emit(aluWord(opSub, 5'd1, 5'd1, 5'd2));
        emit(immWord(opBeq, 5'd0, 5'd1, 2));
        emit(immWord(opJump, 5'd0, 5'd9, 3));
        emit(immWord(opMovi, 5'd4, 5'd0, 55));
        emit(aluWord(opAdd, 5'd5, 5'd3, 5'd4));
      end
    endcase
  endtask

  // Architectural model stepping one instruction at a time in program order
  function automatic int expectedRetires();
    word   regs [32];
    word   pc;
    word   thisPc;
    word   offset;
    word   inst;
    word   imm;
    opcode op;
    regIdx d;
    regIdx a;
    regIdx b;
    int    count;
    int    steps;
    for (int i = 0; i < 32; i++)
      regs[i] = '0;
    pc = resetPc;
    count = 0;
    steps = 0;
    while (steps < maxSteps && pc >= resetPc && (pc - resetPc) < word'(progLen * instBytes))
    begin
      offset = pc - resetPc;
      inst = progMem[offset[6:2]];
      op = opcode'(inst[opcodeLsb +: opcodeBits]);
      d = inst[dstLsb +: regIdxBits];
      a = inst[src1Lsb +: regIdxBits];
      b = inst[src2Lsb +: regIdxBits];
      imm = word'($signed(inst[immBits-1:0]));
      thisPc = pc;
      pc = pc + word'(instBytes);
      case (op)
        opAdd:  regs[d] = regs[a] + regs[b];
        opSub:  regs[d] = regs[a] - regs[b];
        opMovi: regs[d] = imm;
        opBeq:
        begin
          if (regs[a] == regs[b])
            pc = thisPc + (imm << 2);
        end
        opJump: pc = regs[a] + (imm << 2);
        default: ;
      endcase
      // Only register writers show up on the retire port
      if (op == opAdd || op == opSub || op == opMovi)
      begin
        expRegs[count] = d;
        expData[count] = regs[d];
        count++;
      end
      steps++;
    end
    return count;
  endfunction

  // Next word for the instruction port on a falling edge
  task automatic driveFetch();
    word offset;
    offset = instAddr - resetPc;
    if (instAddr >= resetPc && offset < word'(progLen * instBytes))
      instData = progMem[offset[6:2]];
    else
      instData = nopInstruction;
    if (!randomWaits)
      instValid = 1'b1;
    else if (waitLeft > 0)
    begin
      instValid = 1'b0;
      waitLeft--;
    end
    else
    begin
      instValid = 1'b1;
      waitLeft = {$random(seed)} % (maxWait + 1);
    end
  endtask

  task automatic runProgram(input int which, input logic waits);
    int  errs;
    int  pastEnd;
    word endAddr;
    loadProgram(which);
    expCount = expectedRetires();
    endAddr = resetPc + word'(progLen * instBytes);
    randomWaits = waits;
    waitLeft = 0;
    errs = 0;
    instValid = 1'b0;
    instData = nopInstruction;
    runEnd = 1'b0;
    resetRequest = 1'b1;
    @(negedge clk);
    resetRequest = 1'b0;
    @(negedge rst);
    // PC parked at the reset vector while the port idles
    repeat (3)
    begin
      if (instAddr !== resetPc)
      begin
        $display("[ERROR] %0t instAddr got %h expected %h", $time, instAddr, resetPc);
        errs++;
      end
      if (retireValid !== 1'b0)
      begin
        $display("[ERROR] %0t retireValid got %b expected 0", $time, retireValid);
        errs++;
      end
      @(negedge clk);
    end
    // Done once the PC stays past the last word long enough to drain both stages
    pastEnd = 0;
    while (pastEnd < 4)
    begin
      driveFetch();
      @(negedge clk);
      if (instAddr >= endAddr)
        pastEnd++;
      else
        pastEnd = 0;
    end
    instValid = 1'b0;
    runEnd = 1'b1;
    while (!runClosed)
      @(negedge clk);
    errs += checkErrors;
    testsRun++;
    totalErrors += errs;
    if (errs != 0)
      testsFailed++;
    $display("test %s, %s: %0d of %0d retirements seen, %0d errors, %s",
             progName, waits ? "random waits" : "no waits", retiredCount, expCount, errs,
             (errs == 0) ? "ok" : "failed");
  endtask

  initial
  begin
    seed = 32;
    instValid = 1'b0;
    instData = nopInstruction;
    resetRequest = 1'b0;
    runEnd = 1'b0;
    expCount = 0;
    testsRun = 0;
    testsFailed = 0;
    totalErrors = 0;
    for (int p = 0; p < numPrograms; p++)
    begin
      runProgram(p, 1'b0);
      runProgram(p, 1'b1);
    end
    $display("Summary: %0d runs, %0d failed, %0d errors", testsRun, testsFailed, totalErrors);
    if (totalErrors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

  // Watchdog
  initial
  begin
    #(watchdogNs);
    $display("Timeout: the runs did not finish within %0d ns", watchdogNs);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// File: verification/coreChecker.sv
// Retire checker; the expected list must be loaded before reset is released, beats compare in order
`timescale 1ns/100ps

module coreChecker import pipePkg::*;
#(
  parameter int maxRetires = 64
)
(
  input  logic  clk,
  input  logic  rst,
  input  logic  retireValid,
  input  regIdx retireReg,
  input  word   retireData,
  input  int    expCount,
  input  regIdx expRegs [maxRetires],
  input  word   expData [maxRetires],
  input  logic  runEnd,
  output int    retiredCount,
  output int    errorCount,
  output logic  runClosed
);

  // Retire fields are stable over the whole execute cycle, sampled at its closing edge
  always @(posedge clk)
  begin
    if (rst)
    begin
      retiredCount = 0;
      errorCount = 0;
      runClosed = 1'b0;
    end
    else
    begin
      if (retireValid)
      begin
        // Nothing left to match
        if (retiredCount >= expCount)
        begin
          $display("%0t: unexpected retirement of r%0d = %h, all %0d expected ones already seen",
                   $time, retireReg, retireData, expCount);
          errorCount++;
        end
        else
        begin
          if (retireReg !== expRegs[retiredCount])
          begin
            $display("[ERROR] %0t retireReg got %0d expected %0d",
                     $time, retireReg, expRegs[retiredCount]);
            errorCount++;
          end
          if (retireData !== expData[retiredCount])
          begin
            $display("[ERROR] %0t retireData got %h expected %h",
                     $time, retireData, expData[retiredCount]);
            errorCount++;
          end
        end
        retiredCount++;
      end
      // End of run, anything still outstanding never came
      if (runEnd && !runClosed)
      begin
        if (retiredCount < expCount)
        begin
          $display("%0t: run ended with %0d expected retirements missing",
                   $time, expCount - retiredCount);
          errorCount++;
        end
        runClosed = 1'b1;
      end
    end
  end

endmodule

// File: verification/tbClock.sv
// Clock and reset source; a reset request is seen on a rising edge and rst only moves on falling edges
`timescale 1ns/100ps

module tbClock
#(
  parameter int resetCycles = 8,
  parameter int halfPeriod = 2
)
(
  input  logic resetRequest,
  output logic clk,
  output logic rst
);

  // Power-on reset, same length as a requested one
  int   remaining = resetCycles;
  logic rstReg = 1'b1;

  // 4 ns period
  initial
  begin
    clk = 1'b0;
    forever #(halfPeriod) clk = ~clk;
  end

  // Reset cycles still owed
  always @(posedge clk)
  begin
    if (resetRequest)
      remaining <= resetCycles;
    else if (remaining > 0)
      remaining <= remaining - 1;
  end

  // Moved on the falling edge like every other DUT input
  always @(negedge clk)
  begin
    rstReg <= (remaining > 0);
  end

  assign rst = rstReg;

endmodule

// File: rtl/coreTop.sv
// Three-stage core top; instData must be stable while instValid is high, there is no other back-pressure
`timescale 1ns/100ps

module coreTop import pipePkg::*;
#(
  parameter word resetPc = 32'h0000_1000
)
(
  input  logic  clk,
  input  logic  rst,
  output word   instAddr,
  input  word   instData,
  input  logic  instValid,
  output logic  retireValid,
  output regIdx retireReg,
  output word   retireData
);

  word fetchInst;
  word fetchPc;

  issueIf issueBus ();
  resultIf resultBus ();

  fetchUnit #(.resetPc(resetPc)) u_fetchUnit
  (
    .clk       (clk),
    .rst       (rst),
    .instAddr  (instAddr),
    .instData  (instData),
    .instValid (instValid),
    .result    (resultBus.consumer),
    .fetchInst (fetchInst),
    .fetchPc   (fetchPc)
  );

  decodeStage u_decodeStage
  (
    .clk       (clk),
    .rst       (rst),
    .fetchInst (fetchInst),
    .fetchPc   (fetchPc),
    .result    (resultBus.consumer),
    .issue     (issueBus.producer)
  );

  executeStage u_executeStage
  (
    .issue  (issueBus.consumer),
    .result (resultBus.producer)
  );

  // Retire is the writeback itself
  assign retireValid = resultBus.wbValid;
  assign retireReg = resultBus.wbReg;
  assign retireData = resultBus.wbData;

endmodule

// File: rtl/executeStage.sv
// Execute stage; fully combinational, results and redirect are valid only in the issue cycle
`timescale 1ns/100ps

module executeStage import pipePkg::*, isaPkg::*;
(
  issueIf.consumer issue,
  resultIf.producer result
);

  word  aluOut;
  word  target;
  word  offset;
  logic writes;
  logic taken;

  // Offsets count instructions, not bytes
  assign offset = issue.issueImm << 2;

  always_comb
  begin
    aluOut = '0;
    target = issue.issuePc + offset;
    writes = 1'b0;
    taken = 1'b0;
    case (issue.issueOp)
      opAdd:
      begin
        aluOut = issue.issueA + issue.issueB;
        writes = 1'b1;
      end
      opSub:
      begin
        aluOut = issue.issueA - issue.issueB;
        writes = 1'b1;
      end
      opMovi:
      begin
        aluOut = issue.issueImm;
        writes = 1'b1;
      end
      // PC-relative, taken on equal sources
      opBeq:
        taken = (issue.issueA == issue.issueB);
      // Register-relative, always taken
      opJump:
      begin
        target = issue.issueA + offset;
        taken = 1'b1;
      end
      default:
        writes = 1'b0;
    endcase
  end

  // Commit in program order straight to the register file
  assign result.wbValid = issue.issueValid && writes;
  assign result.wbReg = issue.issueDst;
  assign result.wbData = aluOut;

  assign result.redirectValid = issue.issueValid && taken;
  assign result.redirectTarget = target;

endmodule

// File: rtl/decodeStage.sv
// Decode stage; forwards only from execute, which is enough because the pipe has two stages in flight
`timescale 1ns/100ps

module decodeStage import pipePkg::*, isaPkg::*;
(
  input  logic clk,
  input  logic rst,
  input  word  fetchInst,
  input  word  fetchPc,
  resultIf.consumer result,
  issueIf.producer issue
);

  opcode op;
  regIdx dst;
  regIdx src1;
  regIdx src2;
  word   imm;
  word   rfData1;
  word   rfData2;
  word   opA;
  word   opB;
  logic  opKnown;

  // Field split
  assign op = opcode'(fetchInst[opcodeLsb +: opcodeBits]);
  assign dst = fetchInst[dstLsb +: regIdxBits];
  assign src1 = fetchInst[src1Lsb +: regIdxBits];
  assign src2 = fetchInst[src2Lsb +: regIdxBits];

  // Sign extension of the low 15 bits
  assign imm = {{(archBits-immBits){fetchInst[immBits-1]}}, fetchInst[immBits-1:0]};

  // NOP and unknown opcodes never issue
  assign opKnown = (op == opAdd) || (op == opSub) || (op == opMovi) ||
                   (op == opBeq) || (op == opJump);

  // Writeback from execute lands here at the end of the cycle
  registerFile u_registerFile
  (
    .clk     (clk),
    .rst     (rst),
    .rdIdx1  (src1),
    .rdIdx2  (src2),
    .rdData1 (rfData1),
    .rdData2 (rfData2),
    .wrEn    (result.wbValid),
    .wrIdx   (result.wbReg),
    .wrData  (result.wbData)
  );

  // Result being written this cycle is newer than the file contents
  assign opA = (result.wbValid && (result.wbReg == src1)) ? result.wbData : rfData1;
  assign opB = (result.wbValid && (result.wbReg == src2)) ? result.wbData : rfData2;

  // Issue valid, killed by a taken branch in execute
  always_ff @(posedge clk)
  begin
    if (rst)
      issue.issueValid <= 1'b0;
    else
      issue.issueValid <= opKnown && !result.redirectValid;
  end

  // Issue payload, qualified by issueValid
  always_ff @(posedge clk)
  begin
    issue.issueOp <= op;
    issue.issueDst <= dst;
    issue.issueA <= opA;
    issue.issueB <= opB;
    issue.issueImm <= imm;
    issue.issuePc <= fetchPc;
  end

endmodule

// File: rtl/fetchUnit.sv
// Fetch stage; instData is only sampled while instValid is high, no request is issued beyond instAddr
`timescale 1ns/100ps

module fetchUnit import pipePkg::*, isaPkg::*;
#(
  parameter word resetPc = 32'h0000_1000
)
(
  input  logic clk,
  input  logic rst,
  output word  instAddr,
  input  word  instData,
  input  logic instValid,
  resultIf.consumer result,
  output word  fetchInst,
  output word  fetchPc
);

  word pc;

  // Address goes straight out of the PC register
  assign instAddr = pc;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc <= resetPc;
      fetchInst <= nopInstruction;
    end
    // Redirect wins; this cycle's word is dropped
    else if (result.redirectValid)
    begin
      pc <= result.redirectTarget;
      fetchInst <= nopInstruction;
    end
    else if (instValid)
    begin
      pc <= pc + word'(instBytes);
      fetchInst <= instData;
    end
    // Waiting on the instruction port, send a bubble
    else
    begin
      fetchInst <= nopInstruction;
    end
  end

  // PC of the instruction in decode, only meaningful with a real word
  always_ff @(posedge clk)
  begin
    if (instValid && !result.redirectValid)
      fetchPc <= pc;
  end

endmodule

// File: rtl/registerFile.sv
// Register file; no hardwired zero register, write-then-read bypass is left to the caller
`timescale 1ns/100ps

module registerFile import pipePkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  regIdx rdIdx1,
  input  regIdx rdIdx2,
  output word   rdData1,
  output word   rdData2,
  input  logic  wrEn,
  input  regIdx wrIdx,
  input  word   wrData
);

  word regs [2**regIdxBits];

  // Reads are asynchronous
  assign rdData1 = regs[rdIdx1];
  assign rdData2 = regs[rdIdx2];

  always_ff @(posedge clk)
  begin
    // All registers read zero after reset
    if (rst)
    begin
      for (int i = 0; i < 2**regIdxBits; i++)
        regs[i] <= '0;
    end
    else if (wrEn)
      regs[wrIdx] <= wrData;
  end

endmodule

// File: rtl/stageIf.sv
// Stage-to-stage bundles; issueIf is valid-qualified, resultIf carries same-cycle writeback and redirect
`timescale 1ns/100ps

// Decode to execute, one registered instruction per cycle
interface issueIf import pipePkg::*, isaPkg::*; ();

  logic  issueValid;
  opcode issueOp;
  regIdx issueDst;
  // Operands after forwarding
  word   issueA;
  word   issueB;
  // Sign-extended immediate or offset
  word   issueImm;
  word   issuePc;

  modport producer (output issueValid, issueOp, issueDst, issueA, issueB, issueImm, issuePc);
  modport consumer (input issueValid, issueOp, issueDst, issueA, issueB, issueImm, issuePc);

endinterface

// Execute back to decode and fetch, combinational in the execute cycle
interface resultIf import pipePkg::*; ();

  logic  wbValid;
  regIdx wbReg;
  word   wbData;
  logic  redirectValid;
  word   redirectTarget;

  modport producer (output wbValid, wbReg, wbData, redirectValid, redirectTarget);
  modport consumer (input wbValid, wbReg, wbData, redirectValid, redirectTarget);

endinterface

// File: rtl/isaPkg.sv
// Instruction encoding; the 15-bit immediate overlaps source 2, so a BEQ offset shares bits 14..10 with its source 2 index
package isaPkg;

  import pipePkg::*;

  // Opcode field width
  parameter int opcodeBits = 7;

  // Supported opcodes, anything else decodes as a NOP
  typedef enum logic [opcodeBits-1:0]
  {
    opAdd  = 7'h00,
    opSub  = 7'h01,
    opMovi = 7'h15,
    opBeq  = 7'h30,
    opJump = 7'h31,
    opNop  = 7'h7f
  } opcode;

  // Field positions, lsb of each field
  parameter int opcodeLsb = 25;
  parameter int dstLsb = 20;
  parameter int src1Lsb = 15;
  parameter int src2Lsb = 10;

  // Immediate or branch offset width, sign-extended from bit 14
  parameter int immBits = 15;

  // Bubble word, all ones decodes as opNop
  parameter word nopInstruction = 32'hFFFF_FFFF;

endpackage

// File: rtl/pipePkg.sv
// Datapath widths and base types; widths other than 32-bit words and 5-bit indices are untested
package pipePkg;

  // Datapath width, data and address alike
  parameter int archBits = 32;

  // Register index width, 32 architectural registers
  parameter int regIdxBits = 5;

  // Bytes per instruction, the PC step
  parameter int instBytes = 4;

  // Data and address word
  typedef logic [archBits-1:0] word;

  // Register index
  typedef logic [regIdxBits-1:0] regIdx;

endpackage
